// ==== verilog.f ====
rtl/timer_pkg.sv
rtl/apb_pkg.sv
rtl/edge_timer_channel.sv
rtl/timer_regs.sv
rtl/timer_irq.sv
rtl/timer_top.sv
verification/timer_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator from verilog.f and runs it
set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing -sv -Wno-fatal --top-module timer_tb -f verilog.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtimer_tb > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" "$log_file"; then
    echo "run passed"
    exit 0
else
    echo "run failed"
    exit 1
fi

// ==== verification/timer_tb.sv ====
// expects timer_top at the package defaults; stimulus is random from $urandom seeded with 71
`timescale 1ns/1ps

module timer_tb
    import timer_pkg::*;
    import apb_pkg::*;
();

    localparam int num_trials = 200;
    // a trial takes at most about 100 cycles, twice that per trial bounds the run
    localparam int max_cycles = num_trials * 200;
    localparam int drive_dly  = 1;

    typedef enum int {k_none, k_irq_en, k_irq_pend, k_status, k_ctrl, k_dur} reg_kind_t;

    logic     clk = 1'b0;
    logic     reset_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    ch_mask_t trigger;
    ch_mask_t active;
    logic     irq;
    logic     checking;
    int       cycles = 0;

    // reference model state
    ch_ctrl_t m_ctrl [def_num_ch];
    int       m_cnt [def_num_ch];
    ch_mask_t m_busy;
    ch_mask_t m_to;
    ch_mask_t m_to_q;
    ch_mask_t m_pend;
    ch_mask_t m_en;
    ch_mask_t m_active;
    ch_mask_t m_d1;
    ch_mask_t m_d2;
    ch_mask_t m_d3;
    logic     m_irq;
    logic     bus_write;
    logic     pend_clear;
    int       bus_ch;

    timer_top #(
        .WIDTH  (def_width),
        .NUM_CH (def_num_ch)
    ) i_dut (
        .clk     (clk),
        .reset_n (reset_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .trigger (trigger),
        .active  (active),
        .irq     (irq)
    );

    always #2 clk = ~clk;

    function automatic reg_kind_t reg_kind(input addr_t addr);
        int off;
        off = int'(addr) - int'(reg_ch_base);
        if (addr == reg_irq_en)
            return k_irq_en;
        if (addr == reg_irq_pend)
            return k_irq_pend;
        if (addr == reg_status)
            return k_status;
        if (off >= 0 && off < def_num_ch * reg_ch_stride) begin
            if (off % reg_ch_stride == int'(reg_ctrl_off))
                return k_ctrl;
            if (off % reg_ch_stride == int'(reg_dur_off))
                return k_dur;
        end
        return k_none;
    endfunction

    function automatic int reg_chan(input addr_t addr);
        return (int'(addr) - int'(reg_ch_base)) / reg_ch_stride;
    endfunction

    function automatic addr_t ctrl_addr(input int ch);
        return addr_t'(int'(reg_ch_base) + ch * reg_ch_stride);
    endfunction

    function automatic addr_t dur_addr(input int ch);
        return ctrl_addr(ch) + reg_dur_off;
    endfunction

    // a duration of zero still gives a one cycle pulse
    function automatic int span(input count_t dur);
        return (dur == '0) ? 1 : int'(dur);
    endfunction

    function automatic logic [31:0] expected_read(input addr_t addr);
        logic [31:0] word;
        int          ch;
        word = '0;
        ch   = reg_chan(addr);
        case (reg_kind(addr))
            k_irq_en:   word[def_num_ch-1:0] = m_en;
            k_irq_pend: word[def_num_ch-1:0] = m_pend;
            k_status: begin
                word[def_num_ch-1:0]                  = m_active;
                word[status_timeout_lsb +: def_num_ch] = m_to;
            end
            k_ctrl: begin
                word[ctrl_en_bit]   = m_ctrl[ch].enable;
                word[ctrl_edge_bit] = m_ctrl[ch].edge_sel;
            end
            k_dur:      word[def_width-1:0] = m_ctrl[ch].duration;
            default:    word = '0;
        endcase
        return word;
    endfunction

    task automatic fail_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_mask(input string name, input ch_mask_t exp, input ch_mask_t act);
        if (exp !== act) begin
            $display("error: %s expected %h actual %h at %0t", name, exp, act, $time);
            fail_run();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("error: %s expected %h actual %h at %0t", name, exp, act, $time);
            fail_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("error: %s expected %b actual %b at %0t", name, exp, act, $time);
            fail_run();
        end
    endtask

    assign bus_write  = apb_req.psel & apb_req.penable & apb_req.pwrite;
    assign pend_clear = bus_write & (reg_kind(apb_req.paddr) == k_irq_pend);
    assign bus_ch     = reg_chan(apb_req.paddr);

    always_comb begin
        for (int i = 0; i < def_num_ch; i++) begin
            m_active[i] = m_busy[i] & m_ctrl[i].enable;
        end
    end

    // cycle model of the channels, the pending bits and irq, fed from the pins and the bus
    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            m_busy <= '0;
            m_to   <= '0;
            m_to_q <= '0;
            m_pend <= '0;
            m_en   <= '0;
            m_d1   <= '0;
            m_d2   <= '0;
            m_d3   <= '0;
            m_irq  <= 1'b0;
            for (int i = 0; i < def_num_ch; i++) begin
                m_ctrl[i] <= '0;
                m_cnt[i]  <= 0;
            end
        end else begin
            m_d1   <= trigger;
            m_d2   <= m_d1;
            m_d3   <= m_d2;
            m_to_q <= m_to;
            m_irq  <= |(m_pend & m_en);
            for (int i = 0; i < def_num_ch; i++) begin
                if (m_ctrl[i].enable && m_d2[i] != m_d3[i] && m_d2[i] == m_ctrl[i].edge_sel) begin
                    m_busy[i] <= 1'b1;
                    m_cnt[i]  <= 0;
                    m_to[i]   <= 1'b0;
                end else if (m_busy[i] && !m_ctrl[i].enable) begin
                    m_busy[i] <= 1'b0;
                end else if (m_busy[i] && m_cnt[i] + 1 >= span(m_ctrl[i].duration)) begin
                    m_busy[i] <= 1'b0;
                    m_to[i]   <= 1'b1;
                end else if (m_busy[i]) begin
                    m_cnt[i] <= m_cnt[i] + 1;
                end
                if (m_to[i] && !m_to_q[i])
                    m_pend[i] <= 1'b1;
                else if (pend_clear && apb_req.pwdata[i])
                    m_pend[i] <= 1'b0;
            end
            if (bus_write) begin
                case (reg_kind(apb_req.paddr))
                    k_irq_en: m_en <= apb_req.pwdata[def_num_ch-1:0];
                    k_ctrl: begin
                        m_ctrl[bus_ch].enable   <= apb_req.pwdata[ctrl_en_bit];
                        m_ctrl[bus_ch].edge_sel <= edge_sel_t'(apb_req.pwdata[ctrl_edge_bit]);
                    end
                    k_dur:    m_ctrl[bus_ch].duration <= apb_req.pwdata[def_width-1:0];
                    default:  ;
                endcase
            end
        end
    end

    always @(negedge clk) begin
        if (checking) begin
            check_mask("active", m_active, active);
            if (!apb_req.psel)
                check_bit("irq", m_irq, irq);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            fail_run();
        end
    end

    task automatic apb_write(input addr_t addr, input logic [31:0] data);
        @(posedge clk);
        #drive_dly;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(posedge clk);
        #drive_dly;
        apb_req.penable = 1'b1;
        @(negedge clk);
        check_bit("write pready", 1'b1, apb_rsp.pready);
        check_bit("write pslverr", reg_kind(addr) == k_none, apb_rsp.pslverr);
        @(posedge clk);
        #drive_dly;
        apb_req = '0;
    endtask

    task automatic apb_read(input string name, input addr_t addr);
        @(posedge clk);
        #drive_dly;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwdata  = '0;
        @(posedge clk);
        #drive_dly;
        apb_req.penable = 1'b1;
        @(negedge clk);
        check_word(name, expected_read(addr), apb_rsp.prdata);
        check_bit({name, " pready"}, 1'b1, apb_rsp.pready);
        check_bit({name, " pslverr"}, reg_kind(addr) == k_none, apb_rsp.pslverr);
        @(posedge clk);
        #drive_dly;
        apb_req = '0;
    endtask

    task automatic toggle_pin(input int ch);
        @(posedge clk);
        #drive_dly;
        trigger[ch] = ~trigger[ch];
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // edges still in the synchronizer reach the channels before active is polled
    task automatic wait_quiet();
        repeat (4) @(posedge clk);
        @(negedge clk);
        while (active != '0)
            @(negedge clk);
    endtask

    task automatic register_checks();
        addr_t addr;
        apb_read("irq_en after reset", reg_irq_en);
        apb_read("irq_pend after reset", reg_irq_pend);
        apb_read("status after reset", reg_status);
        for (int i = 0; i < def_num_ch; i++) begin
            apb_write(ctrl_addr(i), $urandom);
            apb_write(dur_addr(i), $urandom);
            apb_read("ctrl readback", ctrl_addr(i));
            apb_read("duration readback", dur_addr(i));
        end
        repeat (8) begin
            addr = addr_t'($urandom);
            if (reg_kind(addr) != k_none)
                addr = 12'hffc;
            apb_write(addr, $urandom);
            apb_read("unmapped read", addr);
        end
        for (int i = 0; i < def_num_ch; i++) begin
            apb_read("ctrl after unmapped writes", ctrl_addr(i));
            apb_read("duration after unmapped writes", dur_addr(i));
            apb_write(dur_addr(i), $urandom % 41);
        end
    endtask

    task automatic pulse_trial();
        int          ch;
        int          extra;
        logic [31:0] ctrl_word;
        ch                       = $urandom % def_num_ch;
        extra                    = $urandom % def_num_ch;
        ctrl_word                = '0;
        ctrl_word[ctrl_en_bit]   = ($urandom % 8) != 0;
        ctrl_word[ctrl_edge_bit] = $urandom % 2;
        apb_write(dur_addr(ch), $urandom % 41);
        apb_write(ctrl_addr(ch), ctrl_word);
        toggle_pin(ch);
        if ($urandom % 3 == 0)
            toggle_pin(extra);
        case ($urandom % 4)
            0: begin
                // one of the two later toggles is a selected edge and restarts the count
                idle_cycles(3 + $urandom % 20);
                toggle_pin(ch);
                idle_cycles(2);
                toggle_pin(ch);
            end
            1: begin
                idle_cycles(3 + $urandom % 10);
                ctrl_word[ctrl_en_bit] = 1'b0;
                apb_write(ctrl_addr(ch), ctrl_word);
            end
            default: begin
            end
        endcase
        if ($urandom % 2 == 0)
            apb_write(reg_irq_pend, $urandom);
        wait_quiet();
        apb_read("status", reg_status);
        apb_read("pending", reg_irq_pend);
        if ($urandom % 4 == 0) begin
            apb_write(reg_irq_en, $urandom);
            apb_read("irq_en readback", reg_irq_en);
        end
        if ($urandom % 4 == 0)
            apb_write(reg_irq_pend, $urandom);
        apb_read("pending after clear", reg_irq_pend);
    endtask

    initial begin
        int seed;
        reset_n  = 1'b0;
        apb_req  = '0;
        trigger  = '0;
        checking = 1'b0;
        seed     = $urandom(71);
        repeat (3) @(posedge clk);
        #drive_dly;
        reset_n  = 1'b1;
        checking = 1'b1;
        register_checks();
        repeat (num_trials) pulse_trial();
        wait_quiet();
        apb_read("final status", reg_status);
        apb_read("final pending", reg_irq_pend);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== rtl/timer_top.sv ====
// NUM_CH must equal def_num_ch and WIDTH may not exceed def_width; APB never stalls
`timescale 1ns/1ps

module timer_top
    import timer_pkg::*;
    import apb_pkg::*;
#(
    parameter int WIDTH  = def_width,
    parameter int NUM_CH = def_num_ch
)(
    input  logic     clk,
    input  logic     reset_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    input  ch_mask_t trigger,
    output ch_mask_t active,
    output logic     irq
);

    ch_ctrl_t ch_ctrl [NUM_CH];
    ch_mask_t timeout;
    ch_mask_t irq_en;
    ch_mask_t pending;
    ch_mask_t wdata_mask;
    logic     irq_en_we;
    logic     pend_clr_we;

    timer_regs #(
        .WIDTH  (WIDTH),
        .NUM_CH (NUM_CH)
    ) i_regs (
        .clk         (clk),
        .reset_n     (reset_n),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .ch_ctrl     (ch_ctrl),
        .active      (active),
        .timeout     (timeout),
        .irq_en      (irq_en),
        .pending     (pending),
        .irq_en_we   (irq_en_we),
        .pend_clr_we (pend_clr_we),
        .wdata_mask  (wdata_mask)
    );

    timer_irq #(
        .NUM_CH (NUM_CH)
    ) i_irq (
        .clk         (clk),
        .reset_n     (reset_n),
        .timeout     (timeout),
        .irq_en_we   (irq_en_we),
        .pend_clr_we (pend_clr_we),
        .wdata_mask  (wdata_mask),
        .irq_en      (irq_en),
        .pending     (pending),
        .irq         (irq)
    );

    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        edge_timer_channel #(
            .WIDTH (WIDTH)
        ) i_ch (
            .clk     (clk),
            .reset_n (reset_n),
            .trigger (trigger[i]),
            .ctrl    (ch_ctrl[i]),
            .active  (active[i]),
            .timeout (timeout[i])
        );
    end

endmodule

// ==== rtl/timer_irq.sv ====
// pending bits set on timeout rising edges only; a set and a clear in one cycle leave the bit set
`timescale 1ns/1ps

module timer_irq
    import timer_pkg::*;
#(
    parameter int NUM_CH = def_num_ch
)(
    input  logic     clk,
    input  logic     reset_n,
    input  ch_mask_t timeout,
    input  logic     irq_en_we,
    input  logic     pend_clr_we,
    input  ch_mask_t wdata_mask,
    output ch_mask_t irq_en,
    output ch_mask_t pending,
    output logic     irq
);

    ch_mask_t          timeout_q;
    logic [NUM_CH-1:0] rise;
    logic [NUM_CH-1:0] clr;

    assign rise = timeout[NUM_CH-1:0] & ~timeout_q[NUM_CH-1:0];
    assign clr  = pend_clr_we ? wdata_mask[NUM_CH-1:0] : '0;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            timeout_q <= '0;
            irq_en    <= '0;
            pending   <= '0;
            irq       <= 1'b0;
        end else begin
            timeout_q <= timeout;
            if (irq_en_we) begin
                irq_en <= wdata_mask;
            end
            for (int i = 0; i < NUM_CH; i++) begin
                // a new timeout wins over a clear of the same bit
                if (rise[i]) begin
                    pending[i] <= 1'b1;
                end else if (clr[i]) begin
                    pending[i] <= 1'b0;
                end
            end
            // irq follows the pending bits with one cycle of latency
            irq <= |(pending & irq_en);
        end
    end

endmodule

// ==== rtl/timer_regs.sv ====
// zero-wait APB slave; unaligned or unmapped addresses error, STATUS is read-only and ignores writes
`timescale 1ns/1ps

module timer_regs
    import timer_pkg::*;
    import apb_pkg::*;
#(
    parameter int WIDTH  = def_width,
    parameter int NUM_CH = def_num_ch
)(
    input  logic     clk,
    input  logic     reset_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    output ch_ctrl_t ch_ctrl [NUM_CH],
    input  ch_mask_t active,
    input  ch_mask_t timeout,
    input  ch_mask_t irq_en,
    input  ch_mask_t pending,
    output logic     irq_en_we,
    output logic     pend_clr_we,
    output ch_mask_t wdata_mask
);

    logic              access;
    logic              wr_en;
    logic [NUM_CH-1:0] ctrl_hit;
    logic [NUM_CH-1:0] dur_hit;
    logic              global_hit;
    logic              mapped;
    logic [31:0]       rdata;

    function automatic addr_t ch_addr(input int ch, input addr_t off);
        ch_addr = addr_t'(reg_ch_base + ch * reg_ch_stride) + off;
    endfunction

    assign access = apb_req.psel & apb_req.penable;
    assign wr_en  = access & apb_req.pwrite;

    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            ctrl_hit[i] = (apb_req.paddr == ch_addr(i, reg_ctrl_off));
            dur_hit[i]  = (apb_req.paddr == ch_addr(i, reg_dur_off));
        end
    end

    assign global_hit = (apb_req.paddr == reg_irq_en) |
                        (apb_req.paddr == reg_irq_pend) |
                        (apb_req.paddr == reg_status);
    assign mapped     = global_hit | (|ctrl_hit) | (|dur_hit);

    // the enable and pending registers live in the interrupt block
    assign irq_en_we   = wr_en & (apb_req.paddr == reg_irq_en);
    assign pend_clr_we = wr_en & (apb_req.paddr == reg_irq_pend);
    assign wdata_mask  = apb_req.pwdata[NUM_CH-1:0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_CH; i++) begin
                ch_ctrl[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_CH; i++) begin
                if (wr_en && ctrl_hit[i]) begin
                    ch_ctrl[i].enable   <= apb_req.pwdata[ctrl_en_bit];
                    ch_ctrl[i].edge_sel <= edge_sel_t'(apb_req.pwdata[ctrl_edge_bit]);
                end
                if (wr_en && dur_hit[i]) begin
                    ch_ctrl[i].duration <= count_t'(apb_req.pwdata[WIDTH-1:0]);
                end
            end
        end
    end

    always_comb begin
        rdata = '0;
        case (apb_req.paddr)
            reg_irq_en: begin
                rdata[NUM_CH-1:0] = irq_en;
            end
            reg_irq_pend: begin
                rdata[NUM_CH-1:0] = pending;
            end
            reg_status: begin
                rdata[NUM_CH-1:0]                    = active;
                rdata[status_timeout_lsb +: NUM_CH] = timeout;
            end
            default: begin
                rdata = '0;
            end
        endcase
        for (int i = 0; i < NUM_CH; i++) begin
            if (ctrl_hit[i]) begin
                rdata[ctrl_en_bit]   = ch_ctrl[i].enable;
                rdata[ctrl_edge_bit] = ch_ctrl[i].edge_sel;
            end
            if (dur_hit[i]) begin
                rdata[WIDTH-1:0] = ch_ctrl[i].duration[WIDTH-1:0];
            end
        end
    end

    // read data is driven for any selected read; unmapped addresses decode to zero above
    assign apb_rsp.prdata  = (apb_req.psel & ~apb_req.pwrite) ? rdata : '0;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access & ~mapped;

endmodule

// ==== rtl/edge_timer_channel.sv ====
// trigger is asynchronous and idles low after reset; pulses shorter than two clocks may be missed
`timescale 1ns/1ps

module edge_timer_channel
    import timer_pkg::*;
#(
    parameter int WIDTH = def_width
)(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     trigger,
    input  ch_ctrl_t ctrl,
    output logic     active,
    output logic     timeout
);

    logic        sync_q1;
    logic        sync_q2;
    logic        sync_prev;
    logic        edge_hit;
    logic        accept;
    chan_state_t state_q;
    count_t      count_q;
    count_t      count_d;
    count_t      dur;
    count_t      limit_m1;
    logic        done_q;

    // two flops for metastability, the third holds the previous sample for edge detection
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sync_q1   <= 1'b0;
            sync_q2   <= 1'b0;
            sync_prev <= 1'b0;
        end else begin
            sync_q1   <= trigger;
            sync_q2   <= sync_q1;
            sync_prev <= sync_q2;
        end
    end

    assign edge_hit = (ctrl.edge_sel == edge_rising) ? (sync_q2 & ~sync_prev)
                                                     : (~sync_q2 & sync_prev);
    assign accept   = ctrl.enable & edge_hit;

    // only the low WIDTH bits of the programmed duration take part in the count
    assign dur      = count_t'(ctrl.duration[WIDTH-1:0]);
    assign limit_m1 = (dur == '0) ? '0 : dur - 1'b1;

    always_comb begin
        if (accept) begin
            count_d = '0;
        end else if (state_q == st_counting) begin
            count_d = count_q + 1'b1;
        end else begin
            count_d = count_q;
        end
    end

    // done_q is evaluated on the value the counter is about to take, so the end-of-count
    // decision is ready at the start of the last active cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= st_idle;
            count_q <= '0;
            done_q  <= 1'b0;
            timeout <= 1'b0;
        end else begin
            count_q <= count_d;
            done_q  <= (count_d >= limit_m1);
            case (state_q)
                st_idle: begin
                    if (accept) begin
                        state_q <= st_counting;
                        timeout <= 1'b0;
                    end
                end
                st_counting: begin
                    if (accept) begin
                        // a retrigger restarts the count and keeps the channel busy
                        timeout <= 1'b0;
                    end else if (!ctrl.enable) begin
                        state_q <= st_idle;
                    end else if (done_q) begin
                        state_q <= st_idle;
                        timeout <= 1'b1;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // clearing enable drops the output in the same cycle, the FSM follows a cycle later
    assign active = (state_q == st_counting) & ctrl.enable;

endmodule

// ==== rtl/apb_pkg.sv ====
// APB3-style bus with a 12-bit address and 32-bit data; the slave never inserts wait states
package apb_pkg;

    typedef logic [11:0] addr_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        addr_t       paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // global registers
    localparam addr_t reg_irq_en   = 12'h000;
    localparam addr_t reg_irq_pend = 12'h004;
    localparam addr_t reg_status   = 12'h008;

    // each channel owns a block of reg_ch_stride bytes starting at reg_ch_base
    localparam addr_t reg_ch_base   = 12'h010;
    localparam int    reg_ch_stride = 8;
    localparam addr_t reg_ctrl_off  = 12'h000;
    localparam addr_t reg_dur_off   = 12'h004;

    localparam int status_timeout_lsb = 16;
    localparam int ctrl_en_bit        = 0;
    localparam int ctrl_edge_bit      = 1;

endpackage

// ==== rtl/timer_pkg.sv ====
// typedefs are sized by def_width and def_num_ch; timer_top must use NUM_CH equal to def_num_ch
package timer_pkg;

    // widest supported count and the channel count that sizes the mask vectors
    localparam int def_width  = 16;
    localparam int def_num_ch = 4;

    typedef logic [def_width-1:0] count_t;

    // one bit per channel, used for active, timeout, pending and enable
    typedef logic [def_num_ch-1:0] ch_mask_t;

    typedef enum logic {
        edge_falling = 1'b0,
        edge_rising  = 1'b1
    } edge_sel_t;

    // per-channel programming as it leaves the register block
    typedef struct packed {
        logic      enable;
        edge_sel_t edge_sel;
        count_t    duration;
    } ch_ctrl_t;

    typedef enum logic {
        st_idle     = 1'b0,
        st_counting = 1'b1
    } chan_state_t;

endpackage
